// ==== byte_mover.f ====
+incdir+common
common/byte_mover_pkg.sv
read_port/obi_read_port.sv
buffer/lane_buffer.sv
write_port/obi_write_port.sv
design/byte_mover_top.sv
testbench/tb_obi_memory.sv
testbench/tb_byte_mover.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the byte mover testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_byte_mover \
    -f byte_mover.f \
    -o tb_byte_mover

./obj_dir/tb_byte_mover

// ==== testbench/tb_byte_mover.sv ====
// Byte mover testbench

`timescale 1ns/1ps
`include "byte_mover_params.svh"

module tb_byte_mover import byte_mover_pkg::*; ();

    logic      clk;
    logic      rst_n;
    obi_req_t  read_req;
    obi_rsp_t  read_rsp;
    obi_req_t  write_req;
    obi_rsp_t  write_rsp;
    meta_req_t ar_req;
    logic      ar_valid;
    logic      ar_ready;
    dp_req_t   r_req;
    logic      r_req_valid;
    logic      r_req_ready;
    dp_rsp_t   r_rsp;
    logic      r_rsp_valid;
    logic      r_rsp_ready;
    meta_req_t aw_req;
    logic      aw_valid;
    logic      aw_ready;
    dp_req_t   w_req;
    logic      w_req_valid;
    logic      w_req_ready;
    dp_rsp_t   w_rsp;
    logic      w_rsp_valid;
    logic      w_rsp_ready = 1'b1;
    logic      r_dp_busy;
    logic      w_dp_busy;
    logic      buffer_busy;

    // Beats waiting for the drivers and responses waiting for the compare process
    meta_req_t rd_meta_q [$];
    dp_req_t   rd_dp_q [$];
    meta_req_t wr_meta_q [$];
    dp_req_t   wr_dp_q [$];
    dp_rsp_t   exp_r_rsp_q [$];
    dp_rsp_t   exp_w_rsp_q [$];

    byte_t exp_dst [1 << `BM_ADDR_WIDTH];
    int    r_seen = 0;
    int    w_seen = 0;
    int    r_goal = 0;
    int    w_goal = 0;
    int    beats_issued = 0;
    int    stall_left = 0;
    logic  stall_en;

    byte_mover_top uut (
        .clk_i         ( clk         ),
        .rst_n_i       ( rst_n       ),
        .read_req_o    ( read_req    ),
        .read_rsp_i    ( read_rsp    ),
        .write_req_o   ( write_req   ),
        .write_rsp_i   ( write_rsp   ),
        .ar_req_i      ( ar_req      ),
        .ar_valid_i    ( ar_valid    ),
        .ar_ready_o    ( ar_ready    ),
        .r_dp_req_i    ( r_req       ),
        .r_dp_valid_i  ( r_req_valid ),
        .r_dp_ready_o  ( r_req_ready ),
        .r_dp_rsp_o    ( r_rsp       ),
        .r_dp_valid_o  ( r_rsp_valid ),
        .r_dp_ready_i  ( r_rsp_ready ),
        .aw_req_i      ( aw_req      ),
        .aw_valid_i    ( aw_valid    ),
        .aw_ready_o    ( aw_ready    ),
        .w_dp_req_i    ( w_req       ),
        .w_dp_valid_i  ( w_req_valid ),
        .w_dp_ready_o  ( w_req_ready ),
        .w_dp_rsp_o    ( w_rsp       ),
        .w_dp_valid_o  ( w_rsp_valid ),
        .w_dp_ready_i  ( w_rsp_ready ),
        .r_dp_busy_o   ( r_dp_busy   ),
        .w_dp_busy_o   ( w_dp_busy   ),
        .buffer_busy_o ( buffer_busy )
    );

    tb_obi_memory #(.FillKey(8'h5a)) src_mem (
        .clk_i   ( clk      ),
        .rst_n_i ( rst_n    ),
        .req_i   ( read_req ),
        .rsp_o   ( read_rsp )
    );

    tb_obi_memory #(.FillKey(8'hc3)) dst_mem (
        .clk_i   ( clk       ),
        .rst_n_i ( rst_n     ),
        .req_i   ( write_req ),
        .rsp_o   ( write_rsp )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Reporting and compare tasks
    // --------------------------------------------------

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_rsp(input string name, input dp_rsp_t got, input dp_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s.err got 0x%0h expected 0x%0h", name, got.err, exp.err));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Destination byte after a copy of len bytes from src to dst
    function automatic byte_t expected_byte(input addr_t a, input addr_t src,
                                            input addr_t dst, input int len);
        int rel;
        rel = int'(addr_t'(a - dst));
        if (rel < len) begin
            return src_mem.mem[addr_t'(src + rel)];
        end
        return exp_dst[a];
    endfunction

    // --------------------------------------------------
    // Channel drivers
    // --------------------------------------------------

    task automatic drive_reads();
        meta_req_t m;
        dp_req_t   d;
        @(posedge clk);
        while (rd_meta_q.size() > 0) begin
            m = rd_meta_q.pop_front();
            d = rd_dp_q.pop_front();
            ar_req      <= m;
            r_req       <= d;
            ar_valid    <= 1'b1;
            r_req_valid <= 1'b1;
            // Ready seen mid cycle means the transfer is on the next rising edge
            do begin
                @(negedge clk);
            end while (!(ar_ready && r_req_ready));
            @(posedge clk);
        end
        ar_valid    <= 1'b0;
        r_req_valid <= 1'b0;
    endtask

    task automatic drive_writes();
        meta_req_t m;
        dp_req_t   d;
        @(posedge clk);
        while (wr_meta_q.size() > 0) begin
            m = wr_meta_q.pop_front();
            d = wr_dp_q.pop_front();
            aw_req      <= m;
            w_req       <= d;
            aw_valid    <= 1'b1;
            w_req_valid <= 1'b1;
            do begin
                @(negedge clk);
            end while (!(aw_ready && w_req_ready));
            @(posedge clk);
        end
        aw_valid    <= 1'b0;
        w_req_valid <= 1'b0;
    endtask

    // Split a copy into read and write beats, run it and check the result
    task automatic copy_bytes(input addr_t src, input addr_t dst, input int len);
        addr_t     src_end;
        addr_t     dst_end;
        int        n_rd;
        int        n_wr;
        meta_req_t m;
        dp_req_t   d;
        dp_rsp_t   e;
        byte_t     exp;
        src_end = addr_t'(src + addr_t'(len - 1));
        dst_end = addr_t'(dst + addr_t'(len - 1));
        n_rd = int'(src_end >> 2) - int'(src >> 2) + 1;
        n_wr = int'(dst_end >> 2) - int'(dst >> 2) + 1;
        for (int i = 0; i < n_rd; i++) begin
            m.addr   = (src & ~addr_t'(3)) + addr_t'(4 * i);
            d.offset = (i == 0) ? src[1:0] : 2'd0;
            d.tailer = (i == n_rd - 1) ? 2'd3 - src_end[1:0] : 2'd0;
            d.shift  = src[1:0] - dst[1:0];
            e.err    = (m.addr >= 16'hF000);
            rd_meta_q.push_back(m);
            rd_dp_q.push_back(d);
            exp_r_rsp_q.push_back(e);
        end
        for (int i = 0; i < n_wr; i++) begin
            m.addr   = (dst & ~addr_t'(3)) + addr_t'(4 * i);
            d.offset = (i == 0) ? dst[1:0] : 2'd0;
            d.tailer = (i == n_wr - 1) ? 2'd3 - dst_end[1:0] : 2'd0;
            d.shift  = 2'd0;
            e.err    = 1'b0;
            wr_meta_q.push_back(m);
            wr_dp_q.push_back(d);
            exp_w_rsp_q.push_back(e);
        end
        r_goal       = r_goal + n_rd;
        w_goal       = w_goal + n_wr;
        beats_issued = beats_issued + n_rd + n_wr;
        fork
            drive_reads();
            drive_writes();
        join
        while (r_seen < r_goal || w_seen < w_goal) begin
            @(negedge clk);
        end
        // Quiet period so a duplicated response would still show up
        repeat (4) @(negedge clk);
        if (r_seen != r_goal || w_seen != w_goal) begin
            abort_run($sformatf("responses lost or duplicated, read %0d of %0d, write %0d of %0d",
                                r_seen, r_goal, w_seen, w_goal));
        end
        check_flag("r_dp_busy_o", r_dp_busy, 1'b0);
        check_flag("w_dp_busy_o", w_dp_busy, 1'b0);
        check_flag("buffer_busy_o", buffer_busy, 1'b0);
        for (int a = int'(dst) - 4; a < int'(dst) + len + 4; a++) begin
            exp = expected_byte(addr_t'(a), src, dst, len);
            check_byte($sformatf("dst[0x%04h]", a), dst_mem.mem[addr_t'(a)], exp);
            exp_dst[addr_t'(a)] = exp;
        end
    endtask

    // --------------------------------------------------
    // Response compare and write response stalls
    // --------------------------------------------------

    always @(negedge clk) begin
        if (rst_n && r_rsp_valid && r_rsp_ready) begin
            if (exp_r_rsp_q.size() == 0) begin
                abort_run("read port returned a response with no beat outstanding");
            end else begin
                check_rsp("r_dp_rsp_o", r_rsp, exp_r_rsp_q.pop_front());
                r_seen = r_seen + 1;
            end
        end
        if (rst_n && w_rsp_valid && w_rsp_ready) begin
            if (exp_w_rsp_q.size() == 0) begin
                abort_run("write port returned a response with no beat outstanding");
            end else begin
                check_rsp("w_dp_rsp_o", w_rsp, exp_w_rsp_q.pop_front());
                w_seen = w_seen + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (stall_left > 0) begin
            w_rsp_ready <= 1'b0;
            stall_left  <= stall_left - 1;
        end else if (stall_en && $urandom_range(3, 0) == 0) begin
            w_rsp_ready <= 1'b0;
            stall_left  <= $urandom_range(6, 1);
        end else begin
            w_rsp_ready <= 1'b1;
        end
    end

    // Budget grows with every beat handed to the DUT
    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > 1000 + 200 * beats_issued) begin
                abort_run("watchdog timeout, the copies did not finish in time");
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        int idx;
        int len;
        void'($urandom(32'h7126));
        rst_n       = 1'b0;
        ar_req      = '0;
        ar_valid    = 1'b0;
        r_req       = '0;
        r_req_valid = 1'b0;
        r_rsp_ready = 1'b1;
        aw_req      = '0;
        aw_valid    = 1'b0;
        w_req       = '0;
        w_req_valid = 1'b0;
        stall_en    = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("r_dp_valid_o", r_rsp_valid, 1'b0);
        check_flag("w_dp_valid_o", w_rsp_valid, 1'b0);
        check_flag("ar_ready_o", ar_ready, 1'b1);
        check_flag("aw_ready_o", aw_ready, 1'b1);
        check_flag("r_dp_ready_o", r_req_ready, 1'b1);
        check_flag("w_dp_ready_o", w_req_ready, 1'b1);
        check_flag("buffer_busy_o", buffer_busy, 1'b0);
        for (int a = 0; a < (1 << `BM_ADDR_WIDTH); a++) begin
            exp_dst[addr_t'(a)] = dst_mem.mem[addr_t'(a)];
        end

        // Aligned copy
        copy_bytes(16'h0100, 16'h2100, 16);

        // Every alignment pair and short lengths
        idx = 0;
        for (int s = 0; s < 4; s++) begin
            for (int d = 0; d < 4; d++) begin
                for (len = 1; len <= 13; len++) begin
                    copy_bytes(addr_t'(16'h0400 + 64 * idx + s),
                               addr_t'(16'h3000 + 64 * idx + d), len);
                    idx = idx + 1;
                end
            end
        end

        // Write responses stalled in random stretches
        stall_en = 1'b1;
        for (int i = 0; i < 24; i++) begin
            copy_bytes(addr_t'(16'h0800 + $urandom_range(255, 0)),
                       addr_t'(16'h8000 + 128 * i + $urandom_range(3, 0)),
                       int'($urandom_range(40, 1)));
        end
        stall_en = 1'b0;

        // Source beats in the error region
        copy_bytes(16'hF011, 16'h9000, 10);
        copy_bytes(16'hEFFA, 16'h9102, 12);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== testbench/tb_obi_memory.sv ====
// Behavioral OBI memory

`timescale 1ns/1ps
`include "byte_mover_params.svh"

module tb_obi_memory import byte_mover_pkg::*; #(
    parameter logic [7:0] FillKey = 8'h00
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  obi_req_t req_i,
    output obi_rsp_t rsp_o
);

    localparam int unsigned Size = 1 << `BM_ADDR_WIDTH;

    byte_t      mem [Size];
    logic [1:0] delay_q;
    logic       gnt;
    logic       rvalid_q;
    logic       err_q;
    data_t      rdata_q;

    // Every byte depends on its whole address
    initial begin
        for (int a = 0; a < Size; a++) begin
            mem[a] <= byte_t'((a * 37) ^ (a >> 8) ^ int'(FillKey));
        end
    end

    assign gnt = req_i.req && (delay_q == 2'd0);

    always_comb begin
        rsp_o        = '0;
        rsp_o.gnt    = gnt;
        rsp_o.rvalid = rvalid_q;
        rsp_o.err    = err_q;
        rsp_o.rdata  = rdata_q;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            delay_q  <= 2'd0;
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            // Answer one cycle after the grant
            rvalid_q <= gnt;
            if (gnt) begin
                delay_q <= 2'($urandom_range(3, 0));
                err_q   <= (req_i.addr >= 16'hF000);
                for (int k = 0; k < `BM_STRB_WIDTH; k++) begin
                    rdata_q[8*k +: 8] <= mem[{req_i.addr[`BM_ADDR_WIDTH-1:2], 2'(k)}];
                    if (req_i.we && req_i.be[k]) begin
                        mem[{req_i.addr[`BM_ADDR_WIDTH-1:2], 2'(k)}] <= req_i.wdata[8*k +: 8];
                    end
                end
            end else if (req_i.req) begin
                delay_q <= delay_q - 2'd1;
            end
        end
    end

endmodule

// ==== design/byte_mover_top.sv ====
// Byte mover transport layer

`timescale 1ns/1ps
`include "byte_mover_params.svh"

module byte_mover_top import byte_mover_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    output obi_req_t  read_req_o,
    input  obi_rsp_t  read_rsp_i,
    output obi_req_t  write_req_o,
    input  obi_rsp_t  write_rsp_i,

    input  meta_req_t ar_req_i,
    input  logic      ar_valid_i,
    output logic      ar_ready_o,
    input  dp_req_t   r_dp_req_i,
    input  logic      r_dp_valid_i,
    output logic      r_dp_ready_o,
    output dp_rsp_t   r_dp_rsp_o,
    output logic      r_dp_valid_o,
    input  logic      r_dp_ready_i,

    input  meta_req_t aw_req_i,
    input  logic      aw_valid_i,
    output logic      aw_ready_o,
    input  dp_req_t   w_dp_req_i,
    input  logic      w_dp_valid_i,
    output logic      w_dp_ready_o,
    output dp_rsp_t   w_dp_rsp_o,
    output logic      w_dp_valid_o,
    input  logic      w_dp_ready_i,

    output logic      r_dp_busy_o,
    output logic      w_dp_busy_o,
    output logic      buffer_busy_o
);

    // Rotated read bytes heading into the buffer
    byte_t [`BM_STRB_WIDTH-1:0] buf_in_data;
    strb_t                      buf_in_valid;
    strb_t                      buf_in_ready;

    // Destination aligned bytes leaving the buffer
    byte_t [`BM_STRB_WIDTH-1:0] buf_out_data;
    strb_t                      buf_out_valid;
    strb_t                      buf_out_ready;

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------

    obi_read_port i_read_port (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .ar_req_i       ( ar_req_i     ),
        .ar_valid_i     ( ar_valid_i   ),
        .ar_ready_o     ( ar_ready_o   ),
        .r_dp_req_i     ( r_dp_req_i   ),
        .r_dp_valid_i   ( r_dp_valid_i ),
        .r_dp_ready_o   ( r_dp_ready_o ),
        .r_dp_rsp_o     ( r_dp_rsp_o   ),
        .r_dp_valid_o   ( r_dp_valid_o ),
        .r_dp_ready_i   ( r_dp_ready_i ),
        .read_req_o     ( read_req_o   ),
        .read_rsp_i     ( read_rsp_i   ),
        .buffer_data_o  ( buf_in_data  ),
        .buffer_valid_o ( buf_in_valid ),
        .buffer_ready_i ( buf_in_ready )
    );

    // --------------------------------------------------
    // Reorder buffer
    // --------------------------------------------------

    lane_buffer #(
        .Depth ( `BM_BUFFER_DEPTH )
    ) i_lane_buffer (
        .clk_i   ( clk_i         ),
        .rst_n_i ( rst_n_i       ),
        .data_i  ( buf_in_data   ),
        .valid_i ( buf_in_valid  ),
        .ready_o ( buf_in_ready  ),
        .data_o  ( buf_out_data  ),
        .valid_o ( buf_out_valid ),
        .ready_i ( buf_out_ready )
    );

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------

    obi_write_port i_write_port (
        .clk_i          ( clk_i         ),
        .rst_n_i        ( rst_n_i       ),
        .aw_req_i       ( aw_req_i      ),
        .aw_valid_i     ( aw_valid_i    ),
        .aw_ready_o     ( aw_ready_o    ),
        .w_dp_req_i     ( w_dp_req_i    ),
        .w_dp_valid_i   ( w_dp_valid_i  ),
        .w_dp_ready_o   ( w_dp_ready_o  ),
        .w_dp_rsp_o     ( w_dp_rsp_o    ),
        .w_dp_valid_o   ( w_dp_valid_o  ),
        .w_dp_ready_i   ( w_dp_ready_i  ),
        .write_req_o    ( write_req_o   ),
        .write_rsp_i    ( write_rsp_i   ),
        .buffer_data_i  ( buf_out_data  ),
        .buffer_valid_i ( buf_out_valid ),
        .buffer_ready_o ( buf_out_ready )
    );

    // Status
    assign r_dp_busy_o   = r_dp_valid_i;
    // Write side counts as busy while a request waits or the port is mid beat
    assign w_dp_busy_o   = w_dp_valid_i | ~w_dp_ready_o;
    assign buffer_busy_o = |buf_out_valid;

endmodule

// ==== write_port/obi_write_port.sv ====
// OBI write port

`timescale 1ns/1ps
`include "byte_mover_params.svh"

module obi_write_port import byte_mover_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  meta_req_t                  aw_req_i,
    input  logic                       aw_valid_i,
    output logic                       aw_ready_o,
    input  dp_req_t                    w_dp_req_i,
    input  logic                       w_dp_valid_i,
    output logic                       w_dp_ready_o,
    output dp_rsp_t                    w_dp_rsp_o,
    output logic                       w_dp_valid_o,
    input  logic                       w_dp_ready_i,
    output obi_req_t                   write_req_o,
    input  obi_rsp_t                   write_rsp_i,
    input  byte_t [`BM_STRB_WIDTH-1:0] buffer_data_i,
    input  strb_t                      buffer_valid_i,
    output strb_t                      buffer_ready_o
);

    wr_state_e state_q;
    meta_req_t meta_q;
    dp_req_t   dp_q;
    data_t     wdata_q;
    dp_rsp_t   rsp_q;

    logic  accept;
    strb_t need;
    logic  lanes_ok;
    logic  pop;
    logic  rsp_in;

    // Register empties before the next beat is taken
    assign aw_ready_o   = (state_q == WR_IDLE);
    assign w_dp_ready_o = (state_q == WR_IDLE);
    assign accept       = (state_q == WR_IDLE) && aw_valid_i && w_dp_valid_i;

    // --------------------------------------------------
    // Lane collection
    // --------------------------------------------------

    assign need     = lane_mask(dp_q.offset, dp_q.tailer);
    assign lanes_ok = (buffer_valid_i & need) == need;
    assign pop      = (state_q == WR_WAIT_LANES) && lanes_ok;

    // All needed lanes leave the buffer together
    assign buffer_ready_o = pop ? need : '0;

    always_comb begin
        write_req_o       = '0;
        write_req_o.req   = (state_q == WR_WAIT_GNT);
        write_req_o.we    = 1'b1;
        write_req_o.addr  = meta_q.addr;
        write_req_o.be    = need;
        write_req_o.wdata = wdata_q;
    end

    // --------------------------------------------------
    // Response fall-through register
    // --------------------------------------------------

    assign rsp_in = write_rsp_i.rvalid &&
                    (((state_q == WR_WAIT_GNT) && write_rsp_i.gnt) ||
                     (state_q == WR_WAIT_RSP));

    // HOLD_RSP marks the register as full
    assign w_dp_valid_o   = rsp_in || (state_q == WR_HOLD_RSP);
    assign w_dp_rsp_o.err = (state_q == WR_HOLD_RSP) ? rsp_q.err : write_rsp_i.err;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= WR_IDLE;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (accept) begin
                        state_q <= WR_WAIT_LANES;
                    end
                end
                WR_WAIT_LANES: begin
                    if (lanes_ok) begin
                        state_q <= WR_WAIT_GNT;
                    end
                end
                WR_WAIT_GNT: begin
                    if (rsp_in) begin
                        state_q <= w_dp_ready_i ? WR_IDLE : WR_HOLD_RSP;
                    end else if (write_rsp_i.gnt) begin
                        state_q <= WR_WAIT_RSP;
                    end
                end
                WR_WAIT_RSP: begin
                    if (rsp_in) begin
                        state_q <= w_dp_ready_i ? WR_IDLE : WR_HOLD_RSP;
                    end
                end
                WR_HOLD_RSP: begin
                    if (w_dp_ready_i) begin
                        state_q <= WR_IDLE;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // Beat payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            meta_q <= aw_req_i;
            dp_q   <= w_dp_req_i;
        end
        if (pop) begin
            wdata_q <= buffer_data_i;
        end
        if (rsp_in) begin
            rsp_q.err <= write_rsp_i.err;
        end
    end

    // Every issued write touches at least one lane
    a_be_nonzero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        write_req_o.req |-> (write_req_o.be != '0)
    );

endmodule

// ==== buffer/lane_buffer.sv ====
// Per lane reorder buffer

`timescale 1ns/1ps
`include "byte_mover_params.svh"

module lane_buffer import byte_mover_pkg::*; #(
    parameter int unsigned Depth = 3
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  byte_t [`BM_STRB_WIDTH-1:0] data_i,
    input  strb_t                      valid_i,
    output strb_t                      ready_o,
    output byte_t [`BM_STRB_WIDTH-1:0] data_o,
    output strb_t                      valid_o,
    input  strb_t                      ready_i
);

    localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW = $clog2(Depth + 1);

    // --------------------------------------------------
    // One FIFO per byte lane
    // --------------------------------------------------

    for (genvar i = 0; i < `BM_STRB_WIDTH; i++) begin : gen_lane
        byte_t           mem_q [Depth];
        logic [PtrW-1:0] wr_ptr_q;
        logic [PtrW-1:0] rd_ptr_q;
        logic [CntW-1:0] cnt_q;
        logic            push;
        logic            pop;

        assign ready_o[i] = (cnt_q != CntW'(Depth));
        assign valid_o[i] = (cnt_q != '0);
        assign data_o[i]  = mem_q[rd_ptr_q];

        assign push = valid_i[i] && ready_o[i];
        assign pop  = valid_o[i] && ready_i[i];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
                end
                cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
            end
        end

        always_ff @(posedge clk_i) begin
            if (push) begin
                mem_q[wr_ptr_q] <= data_i[i];
            end
        end

        // A push never lands on an entry that is still unread
        a_no_push_full: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            push |-> ((cnt_q == '0) || (wr_ptr_q != rd_ptr_q))
        );
    end

endmodule

// ==== read_port/obi_read_port.sv ====
// OBI read port

`timescale 1ns/1ps
`include "byte_mover_params.svh"

module obi_read_port import byte_mover_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  meta_req_t                  ar_req_i,
    input  logic                       ar_valid_i,
    output logic                       ar_ready_o,
    input  dp_req_t                    r_dp_req_i,
    input  logic                       r_dp_valid_i,
    output logic                       r_dp_ready_o,
    output dp_rsp_t                    r_dp_rsp_o,
    output logic                       r_dp_valid_o,
    input  logic                       r_dp_ready_i,
    output obi_req_t                   read_req_o,
    input  obi_rsp_t                   read_rsp_i,
    output byte_t [`BM_STRB_WIDTH-1:0] buffer_data_o,
    output strb_t                      buffer_valid_o,
    input  strb_t                      buffer_ready_i
);

    rd_state_e state_q;
    meta_req_t meta_q;
    dp_req_t   dp_q;
    data_t     data_q;
    logic      err_q;
    logic      got_q;
    strb_t     pend_q;
    logic      rsp_valid_q;

    logic  free;
    logic  accept;
    logic  capture;
    logic  lanes_done;
    strb_t rot_mask;

    logic [2*`BM_DATA_WIDTH-1:0] data_dbl;
    logic [2*`BM_STRB_WIDTH-1:0] mask_dbl;

    // A new beat only once the previous response has left
    assign free         = (state_q == RD_IDLE) && !rsp_valid_q;
    assign ar_ready_o   = free;
    assign r_dp_ready_o = free;
    assign accept       = free && ar_valid_i && r_dp_valid_i;

    assign capture = read_rsp_i.rvalid &&
                     (((state_q == RD_WAIT_GNT) && read_rsp_i.gnt) ||
                      ((state_q == RD_WAIT_DATA) && !got_q));

    always_comb begin
        read_req_o      = '0;
        read_req_o.req  = (state_q == RD_WAIT_GNT);
        read_req_o.we   = 1'b0;
        read_req_o.addr = meta_q.addr;
        read_req_o.be   = '1;
    end

    // --------------------------------------------------
    // Rotation into destination lanes
    // --------------------------------------------------

    // Source lane k lands in buffer lane k minus shift
    assign data_dbl = {data_q, data_q} >> {dp_q.shift, 3'b000};
    assign mask_dbl = {2{lane_mask(dp_q.offset, dp_q.tailer)}} >> dp_q.shift;
    assign rot_mask = mask_dbl[`BM_STRB_WIDTH-1:0];

    assign buffer_data_o  = data_dbl[`BM_DATA_WIDTH-1:0];
    assign buffer_valid_o = got_q ? pend_q : '0;

    // Every lane still owed is taken this cycle
    assign lanes_done = (pend_q & ~buffer_ready_i) == '0;

    assign r_dp_valid_o   = rsp_valid_q;
    assign r_dp_rsp_o.err = err_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= RD_IDLE;
            got_q       <= 1'b0;
            pend_q      <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (accept) begin
                        state_q <= RD_WAIT_GNT;
                    end
                end
                RD_WAIT_GNT: begin
                    if (read_rsp_i.gnt) begin
                        state_q <= RD_WAIT_DATA;
                    end
                end
                RD_WAIT_DATA: begin
                    if (got_q && lanes_done) begin
                        state_q <= RD_IDLE;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase

            if (capture) begin
                got_q  <= 1'b1;
                pend_q <= rot_mask;
            end else if (got_q) begin
                pend_q <= pend_q & ~buffer_ready_i;
                if (lanes_done) begin
                    got_q <= 1'b0;
                end
            end

            if (rsp_valid_q && r_dp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
            if (got_q && lanes_done) begin
                rsp_valid_q <= 1'b1;
            end
        end
    end

    // Beat payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            meta_q <= ar_req_i;
            dp_q   <= r_dp_req_i;
        end
        if (capture) begin
            data_q <= read_rsp_i.rdata;
            err_q  <= read_rsp_i.err;
        end
    end

    // Memory answers only an access that was issued
    a_no_rvalid_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !((state_q == RD_IDLE) && read_rsp_i.rvalid)
    );

endmodule

// ==== common/byte_mover_pkg.sv ====
// Byte mover shared types

`include "byte_mover_params.svh"

package byte_mover_pkg;

    typedef logic [7:0]                      byte_t;
    typedef logic [`BM_STRB_WIDTH-1:0]       strb_t;
    typedef logic [`BM_DATA_WIDTH-1:0]       data_t;
    typedef logic [`BM_ADDR_WIDTH-1:0]       addr_t;
    typedef logic [$clog2(`BM_STRB_WIDTH)-1:0] lane_idx_t;

    // Word aligned address of one bus beat
    typedef struct packed {
        addr_t addr;
    } meta_req_t;

    // Lane control of one beat
    typedef struct packed {
        lane_idx_t offset;
        lane_idx_t tailer;
        lane_idx_t shift;
    } dp_req_t;

    typedef struct packed {
        logic err;
    } dp_rsp_t;

    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        strb_t be;
        data_t wdata;
    } obi_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        logic  err;
        data_t rdata;
    } obi_rsp_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_GNT,
        RD_WAIT_DATA
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_WAIT_LANES,
        WR_WAIT_GNT,
        WR_WAIT_RSP,
        WR_HOLD_RSP
    } wr_state_e;

    // Lanes offset through top minus tailer are in use
    function automatic strb_t lane_mask(input lane_idx_t offset, input lane_idx_t tailer);
        strb_t mask;
        for (int k = 0; k < `BM_STRB_WIDTH; k++) begin
            mask[k] = (k >= offset) && (k <= `BM_STRB_WIDTH - 1 - tailer);
        end
        return mask;
    endfunction

endpackage

// ==== common/byte_mover_params.svh ====
// Byte mover parameters

`ifndef BYTE_MOVER_PARAMS_SVH
`define BYTE_MOVER_PARAMS_SVH

// Bus data width in bits
`define BM_DATA_WIDTH 32

// Byte lanes per bus word
`define BM_STRB_WIDTH 4

// Byte address width
`define BM_ADDR_WIDTH 16

// Entries in each lane FIFO of the reorder buffer
`define BM_BUFFER_DEPTH 3

`endif
